// ==== source/game_pkg.sv ====
package game_pkg;

    // tile codes, anything from plate 1 upward is solid
    typedef logic [3:0] tile_t;

    localparam tile_t TILE_EMPTY  = 4'd0;
    localparam tile_t TILE_SPIKE  = 4'd1;
    localparam tile_t TILE_GATE1  = 4'd2;
    localparam tile_t TILE_GATE2  = 4'd3;
    localparam tile_t TILE_GATE3  = 4'd4;
    localparam tile_t TILE_PLATE1 = 4'd5;
    localparam tile_t TILE_PLATE2 = 4'd6;
    localparam tile_t TILE_PLATE3 = 4'd7;
    localparam tile_t TILE_EXIT   = 4'd8;
    localparam tile_t TILE_WALL   = 4'd9;

    localparam int MAP_COLS   = 20;
    localparam int MAP_ROWS   = 15;
    localparam int TILE_SHIFT = 5;   // 32 pixel tiles

    typedef enum logic [1:0] {
        scene_start,
        scene_play,
        scene_lose
    } scene_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       jump;
    } joy_sample_t;

    localparam logic [8:0] KEY_START = 9'h016;   // key 1

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       face_left;
        logic       jumping;
        logic       on_ground;
    } char_state_t;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } pos_t;

    localparam logic [9:0] CHAR_SIZE   = 10'd32;
    localparam logic [9:0] STEP        = 10'd5;
    localparam logic [9:0] JUMP_HEIGHT = 10'd64;
    localparam logic [9:0] FLOOR_Y     = 10'd416;
    localparam logic [9:0] X_LIMIT     = 10'd603;   // 640 - 32 - 5
    localparam logic [9:0] JOY_LOW     = 10'd400;
    localparam logic [9:0] JOY_HIGH    = 10'd600;

    localparam pos_t P0_START = '{x: 10'd32, y: 10'd320};
    localparam pos_t P1_START = '{x: 10'd32, y: 10'd416};

    // bit k set means gate k+1 is open
    typedef logic [2:0] gate_mask_t;

    // pixel to tile, clamped so anything past the map stays past it
    function automatic logic [4:0] pix_to_col(input logic [10:0] px);
        logic [5:0] c;
        c = 6'(px >> TILE_SHIFT);
        return (c > 6'd31) ? 5'd31 : c[4:0];
    endfunction

    function automatic logic [3:0] pix_to_row(input logic [10:0] py);
        logic [5:0] r;
        r = 6'(py >> TILE_SHIFT);
        return (r > 6'd15) ? 4'd15 : r[3:0];
    endfunction

endpackage

// ==== source/tile_map.sv ====
`timescale 1ns/100ps

module tile_map (
    input  logic [4:0]      col,
    input  logic [3:0]      row,
    output game_pkg::tile_t tile
);

    localparam game_pkg::tile_t E  = game_pkg::TILE_EMPTY;
    localparam game_pkg::tile_t S  = game_pkg::TILE_SPIKE;
    localparam game_pkg::tile_t G1 = game_pkg::TILE_GATE1;
    localparam game_pkg::tile_t G2 = game_pkg::TILE_GATE2;
    localparam game_pkg::tile_t G3 = game_pkg::TILE_GATE3;
    localparam game_pkg::tile_t P1 = game_pkg::TILE_PLATE1;
    localparam game_pkg::tile_t P2 = game_pkg::TILE_PLATE2;
    localparam game_pkg::tile_t P3 = game_pkg::TILE_PLATE3;
    localparam game_pkg::tile_t X  = game_pkg::TILE_EXIT;
    localparam game_pkg::tile_t W  = game_pkg::TILE_WALL;

    localparam int ROW_W = game_pkg::MAP_COLS * 4;

    // column 0 is the top nibble of each row
    localparam logic [ROW_W-1:0] LEVEL [game_pkg::MAP_ROWS] = '{
        {20{E}},
        {{10{E}}, {10{W}}},
        {20{E}},
        {{10{W}}, {10{E}}},
        {20{E}},
        {{10{W}}, {10{E}}},
        {20{E}},
        {{10{W}}, {10{E}}},
        {20{E}},
        {{7{E}}, G1, {4{E}}, G2, {4{E}}, G3, E, X},
        {{5{E}}, S, E, G1, {4{E}}, G2, {4{E}}, G3, E, X},
        {{2{W}}, {3{P1}}, {15{W}}},   // player 0 ledge, plate 1 at cols 2..4
        {20{E}},
        {{2{E}}, S, E, G1, {10{E}}, {5{P3}}},
        {{5{W}}, {5{P1}}, {5{P2}}, {5{W}}}
    };

    logic [ROW_W-1:0] row_bits;

    always_comb begin
        row_bits = '0;
        tile     = W;   // below the map counts as floor
        if (row < game_pkg::MAP_ROWS) begin
            row_bits = LEVEL[row];
            if (col < game_pkg::MAP_COLS) begin
                tile = row_bits[(game_pkg::MAP_COLS - 1 - col) * 4 +: 4];
            end else begin
                tile = E;
            end
        end
    end

endmodule

// ==== source/character_motion.sv ====
`timescale 1ns/100ps

module character_motion #(
    parameter logic [9:0] START_X = 10'd32,
    parameter logic [9:0] START_Y = 10'd320
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tick,
    input  game_pkg::joy_sample_t  joy,
    input  game_pkg::gate_mask_t   gate_open,
    output game_pkg::char_state_t  state,
    output game_pkg::tile_t        foot_tile
);

    logic [10:0]     px;
    logic [10:0]     py;
    logic [4:0]      probe_col [8];
    logic [3:0]      probe_row [8];
    game_pkg::tile_t probe_tile [8];
    logic            floor_hit;
    logic            wall_r;
    logic            wall_l;
    logic            ceiling_hit;
    logic            go_left;
    logic            go_right;
    logic [9:0]      land_y;
    logic [9:0]      jump_start_y;

    // solid tiles always block, gates only while closed
    function automatic logic blocks(input game_pkg::tile_t t, input game_pkg::gate_mask_t g);
        case (t)
            game_pkg::TILE_GATE1: return !g[0];
            game_pkg::TILE_GATE2: return !g[1];
            game_pkg::TILE_GATE3: return !g[2];
            default:              return t >= game_pkg::TILE_PLATE1;
        endcase
    endfunction

    assign px = {1'b0, state.x};
    assign py = {1'b0, state.y};

    // probe pairs: 0/1 floor, 2/3 right, 4/5 left, 6/7 ceiling
    always_comb begin
        probe_col[0] = game_pkg::pix_to_col(px + 11'd4);    // left foot
        probe_col[1] = game_pkg::pix_to_col(px + 11'(game_pkg::CHAR_SIZE) - 11'd4);
        probe_row[0] = game_pkg::pix_to_row(py + 11'(game_pkg::CHAR_SIZE));
        probe_row[1] = probe_row[0];

        probe_col[2] = game_pkg::pix_to_col(px + 11'(game_pkg::CHAR_SIZE - 10'd1)
                                            + 11'(game_pkg::STEP));
        probe_col[3] = probe_col[2];
        probe_row[2] = game_pkg::pix_to_row(py + 11'(game_pkg::CHAR_SIZE >> 1));   // mid body
        probe_row[3] = game_pkg::pix_to_row(py + 11'd4);                            // head

        // wraps below x of 5, but the screen edge stops that move anyway
        probe_col[4] = game_pkg::pix_to_col(px - 11'(game_pkg::STEP));
        probe_col[5] = probe_col[4];
        probe_row[4] = probe_row[2];
        probe_row[5] = probe_row[3];

        probe_col[6] = probe_col[0];
        probe_col[7] = probe_col[1];
        probe_row[6] = game_pkg::pix_to_row(py - 11'd1);   // y of 0 reads as wall
        probe_row[7] = probe_row[6];
    end

    for (genvar i = 0; i < 8; i++) begin : g_probe
        tile_map u_map (
            .col  (probe_col[i]),
            .row  (probe_row[i]),
            .tile (probe_tile[i])
        );
    end

    assign foot_tile   = probe_tile[0];
    assign floor_hit   = blocks(probe_tile[0], gate_open) || blocks(probe_tile[1], gate_open);
    assign wall_r      = blocks(probe_tile[2], gate_open) || blocks(probe_tile[3], gate_open);
    assign wall_l      = blocks(probe_tile[4], gate_open) || blocks(probe_tile[5], gate_open);
    assign ceiling_hit = blocks(probe_tile[6], gate_open) || blocks(probe_tile[7], gate_open);

    assign go_left  = joy.x < game_pkg::JOY_LOW;
    assign go_right = joy.x > game_pkg::JOY_HIGH;
    assign land_y   = (10'(probe_row[0]) << game_pkg::TILE_SHIFT) - game_pkg::CHAR_SIZE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= '{x: START_X, y: START_Y, face_left: 1'b0, jumping: 1'b0, on_ground: 1'b1};
        end else if (tick) begin
            if (go_left && state.x >= game_pkg::STEP && !wall_l) begin
                state.x         <= state.x - game_pkg::STEP;
                state.face_left <= 1'b1;
            end else if (go_right && state.x < game_pkg::X_LIMIT && !wall_r) begin
                state.x         <= state.x + game_pkg::STEP;
                state.face_left <= 1'b0;
            end

            if (state.jumping) begin
                if (ceiling_hit ||
                    11'(state.y) + 11'(game_pkg::JUMP_HEIGHT) <= 11'(jump_start_y) ||
                    state.y <= 10'd10) begin
                    state.jumping <= 1'b0;   // top of the arc
                end else begin
                    state.y <= state.y - game_pkg::STEP;
                end
            end else if (floor_hit || state.y >= game_pkg::FLOOR_Y) begin
                state.on_ground <= 1'b1;
                state.y         <= (state.y >= game_pkg::FLOOR_Y) ? game_pkg::FLOOR_Y : land_y;
            end else begin
                state.on_ground <= 1'b0;
                state.y         <= state.y + game_pkg::STEP;
            end

            // takes priority over the landing update above
            if (joy.jump && state.on_ground && !state.jumping) begin
                state.jumping   <= 1'b1;
                state.on_ground <= 1'b0;
                jump_start_y    <= state.y;
            end
        end
    end

endmodule

// ==== source/gate_control.sv ====
`timescale 1ns/100ps

module gate_control (
    input  game_pkg::tile_t      foot0,
    input  game_pkg::tile_t      foot1,
    output game_pkg::gate_mask_t gate_open
);

    // gate k+1 opens while either player stands on plate k+1
    always_comb begin
        for (int k = 0; k < $bits(game_pkg::gate_mask_t); k++) begin
            gate_open[k] = (foot0 == game_pkg::TILE_PLATE1 + k) ||
                           (foot1 == game_pkg::TILE_PLATE1 + k);
        end
    end

endmodule

// ==== source/spike_timer.sv ====
`timescale 1ns/100ps

module spike_timer #(
    parameter int SPIKE_TICKS = 100_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic spike_on
);

    localparam int CNT_W = $clog2(SPIKE_TICKS + 1);

    logic [CNT_W-1:0] cnt;
    logic [3:0]       spike_sec;
    logic [3:0]       sec_next;
    logic             sec_done;

    assign sec_done = cnt == CNT_W'(SPIKE_TICKS - 1);
    assign sec_next = sec_done ? spike_sec + 4'd1 : spike_sec;   // wraps at 16

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            spike_sec <= 4'd0;
            spike_on  <= 1'b0;
        end else begin
            cnt       <= sec_done ? '0 : cnt + 1'b1;
            spike_sec <= sec_next;
            // registered from the next count so it tracks spike_sec exactly
            spike_on  <= sec_next > 4'd4;
        end
    end

endmodule

// ==== source/scene_fsm.sv ====
`timescale 1ns/100ps

module scene_fsm #(
    parameter int LOSE_TICKS   = 100_000_000,
    parameter int LOSE_SECONDS = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_valid,
    input  logic [8:0]            key_code,
    input  logic                  spike_on,
    input  game_pkg::char_state_t char0,
    input  game_pkg::char_state_t char1,
    output game_pkg::scene_t      scene
);

    localparam int TICK_W = $clog2(LOSE_TICKS + 1);
    localparam int SEC_W  = $clog2(LOSE_SECONDS + 1);

    game_pkg::char_state_t chars [2];
    logic [4:0]            corner_col [4];
    logic [3:0]            corner_row [4];
    game_pkg::tile_t       corner_tile [4];
    logic [3:0]            spike_hit;
    logic                  spike_contact;
    game_pkg::scene_t      next_scene;
    logic [TICK_W-1:0]     lose_cnt;
    logic [SEC_W-1:0]      lose_sec;
    logic                  lose_done;

    assign chars[0] = char0;
    assign chars[1] = char1;

    // even probes bottom-left, odd probes bottom-right
    for (genvar i = 0; i < 4; i++) begin : g_corner
        localparam int         C  = i / 2;
        localparam logic [9:0] DX = (i % 2 == 1) ? game_pkg::CHAR_SIZE - 10'd1 : 10'd0;

        assign corner_col[i] = game_pkg::pix_to_col(11'(chars[C].x) + 11'(DX));
        assign corner_row[i] = game_pkg::pix_to_row(11'(chars[C].y)
                                                    + 11'(game_pkg::CHAR_SIZE - 10'd1));

        tile_map u_map (
            .col  (corner_col[i]),
            .row  (corner_row[i]),
            .tile (corner_tile[i])
        );

        assign spike_hit[i] = corner_tile[i] == game_pkg::TILE_SPIKE;
    end

    assign spike_contact = |spike_hit;
    assign lose_done     = lose_sec >= SEC_W'(LOSE_SECONDS);

    always_comb begin
        next_scene = scene;
        case (scene)
            game_pkg::scene_start:
                if (key_valid && key_code == game_pkg::KEY_START) next_scene = game_pkg::scene_play;
            game_pkg::scene_play:
                if (spike_contact && spike_on) next_scene = game_pkg::scene_lose;
            game_pkg::scene_lose:
                if (lose_done) next_scene = game_pkg::scene_start;
            default:
                next_scene = game_pkg::scene_start;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scene <= game_pkg::scene_start;
        end else begin
            scene <= next_scene;
        end
    end

    // lose hold timer, only runs while staying in the lose scene
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lose_cnt <= '0;
            lose_sec <= '0;
        end else if (scene == game_pkg::scene_lose && next_scene == game_pkg::scene_lose) begin
            if (lose_cnt == TICK_W'(LOSE_TICKS - 1)) begin
                lose_cnt <= '0;
                lose_sec <= lose_sec + 1'b1;
            end else begin
                lose_cnt <= lose_cnt + 1'b1;
            end
        end else begin
            lose_cnt <= '0;
            lose_sec <= '0;
        end
    end

endmodule

// ==== source/game_top.sv ====
`timescale 1ns/100ps

module game_top #(
    parameter int SPIKE_TICKS  = 100_000_000,
    parameter int LOSE_TICKS   = 100_000_000,
    parameter int LOSE_SECONDS = 5
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_valid,
    input  logic [8:0]            key_code,
    input  logic                  tick,
    input  game_pkg::joy_sample_t joy0,
    input  game_pkg::joy_sample_t joy1,
    output game_pkg::scene_t      scene,
    output game_pkg::char_state_t char0,
    output game_pkg::char_state_t char1,
    output game_pkg::gate_mask_t  gate_open,
    output logic                  spike_on
);

    game_pkg::tile_t foot0;
    game_pkg::tile_t foot1;

    character_motion #(
        .START_X (game_pkg::P0_START.x),
        .START_Y (game_pkg::P0_START.y)
    ) u_char0 (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .joy       (joy0),
        .gate_open (gate_open),
        .state     (char0),
        .foot_tile (foot0)
    );

    character_motion #(
        .START_X (game_pkg::P1_START.x),
        .START_Y (game_pkg::P1_START.y)
    ) u_char1 (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .joy       (joy1),
        .gate_open (gate_open),
        .state     (char1),
        .foot_tile (foot1)
    );

    gate_control u_gates (
        .foot0     (foot0),
        .foot1     (foot1),
        .gate_open (gate_open)
    );

    spike_timer #(
        .SPIKE_TICKS (SPIKE_TICKS)
    ) u_spike (
        .clk      (clk),
        .rst      (rst),
        .spike_on (spike_on)
    );

    scene_fsm #(
        .LOSE_TICKS   (LOSE_TICKS),
        .LOSE_SECONDS (LOSE_SECONDS)
    ) u_scene (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_code  (key_code),
        .spike_on  (spike_on),
        .char0     (char0),
        .char1     (char1),
        .scene     (scene)
    );

endmodule

// ==== verification/game_assertions.sv ====
`timescale 1ns/100ps

module game_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic                  tick,
    input game_pkg::char_state_t state
);

    // rising and standing exclude each other
    jump_vs_ground: assert property (@(posedge clk) disable iff (rst)
        !(state.jumping && state.on_ground))
        else $error("jumping and on_ground both set at x=%0d y=%0d", state.x, state.y);

    x_in_range: assert property (@(posedge clk) disable iff (rst)
        state.x <= game_pkg::X_LIMIT + game_pkg::STEP)
        else $error("x out of range at %0d", state.x);

    // state only moves on the edge that saw tick
    moves_on_tick: assert property (@(posedge clk) disable iff (rst)
        (state != $past(state)) |-> $past(tick))
        else $error("character state changed without a tick");

endmodule

bind character_motion game_assertions u_assertions (
    .clk   (clk),
    .rst   (rst),
    .tick  (tick),
    .state (state)
);

// ==== verification/game_tb.sv ====
`timescale 1ns/100ps

module game_tb;

    localparam int SPIKE_TICKS  = 20;
    localparam int LOSE_TICKS   = 10;
    localparam int LOSE_SECONDS = 5;
    localparam int MAX_CYCLES   = 4000;   // whole run needs roughly 400
    localparam logic [9:0] JOY_RIGHT  = 10'd700;
    localparam logic [9:0] JOY_LEFT   = 10'd100;
    localparam logic [9:0] GATE1_STOP = 10'd92;   // last step that clears the gate 1 column
    localparam game_pkg::joy_sample_t JOY_REST = '{x: 10'd512, y: 10'd512, jump: 1'b0};

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  key_valid;
    logic [8:0]            key_code;
    logic                  tick;
    game_pkg::joy_sample_t joy0;
    game_pkg::joy_sample_t joy1;
    game_pkg::scene_t      scene;
    game_pkg::char_state_t char0;
    game_pkg::char_state_t char1;
    game_pkg::gate_mask_t  gate_open;
    logic                  spike_on;

    int checks      = 0;
    int errors      = 0;
    int tests       = 0;
    int cycle_cnt   = 0;
    int since_reset = 0;

    game_top #(
        .SPIKE_TICKS  (SPIKE_TICKS),
        .LOSE_TICKS   (LOSE_TICKS),
        .LOSE_SECONDS (LOSE_SECONDS)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_code  (key_code),
        .tick      (tick),
        .joy0      (joy0),
        .joy1      (joy1),
        .scene     (scene),
        .char0     (char0),
        .char1     (char1),
        .gate_open (gate_open),
        .spike_on  (spike_on)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    // clock edges since reset was released
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            since_reset <= 0;
        end else begin
            since_reset <= since_reset + 1;
        end
    end

    function automatic game_pkg::char_state_t char_at(input logic [9:0] x, input logic [9:0] y,
                                                     input logic face_left,
                                                     input logic on_ground);
        return '{x: x, y: y, face_left: face_left, jumping: 1'b0, on_ground: on_ground};
    endfunction

    function automatic string char_text(input game_pkg::char_state_t c);
        return $sformatf("x=%0d y=%0d f=%b j=%b g=%b", c.x, c.y, c.face_left, c.jumping,
                         c.on_ground);
    endfunction

    // hazard seconds wrap at 16 and are dangerous above 4
    function automatic logic spike_expected(input int edges);
        return ((edges / SPIKE_TICKS) % 16) > 4;
    endfunction

    task automatic check_scene(input string name, input game_pkg::scene_t exp,
                               input game_pkg::scene_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_char(input string name, input game_pkg::char_state_t exp,
                              input game_pkg::char_state_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %s, got %s", $time, name, char_text(exp),
                     char_text(act));
        end
    endtask

    task automatic check_gates(input string name, input game_pkg::gate_mask_t exp,
                               input game_pkg::gate_mask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic apply_reset();
        rst       = 1'b1;
        key_valid = 1'b0;
        key_code  = '0;
        tick      = 1'b0;
        joy0      = JOY_REST;
        joy1      = JOY_REST;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic pulse_tick();
        @(negedge clk);
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
    endtask

    task automatic send_key(input logic [8:0] code);
        @(negedge clk);
        key_valid = 1'b1;
        key_code  = code;
        @(negedge clk);
        key_valid = 1'b0;
    endtask

    task automatic test_reset_and_start();
        int         err_before;
        int         i;
        logic [8:0] code;
        err_before = errors;
        check_scene("scene", game_pkg::scene_start, scene);
        check_bit("spike_on", 1'b0, spike_on);
        check_gates("gate_open", 3'b000, gate_open);
        check_char("char0", char_at(game_pkg::P0_START.x, game_pkg::P0_START.y, 1'b0, 1'b1), char0);
        check_char("char1", char_at(game_pkg::P1_START.x, game_pkg::P1_START.y, 1'b0, 1'b1), char1);
        for (i = 0; i < 8; i++) begin
            code = 9'($urandom % 512);
            if (code == game_pkg::KEY_START) begin
                code = ~code;
            end
            send_key(code);
            check_scene("scene", game_pkg::scene_start, scene);
        end
        send_key(game_pkg::KEY_START);
        check_scene("scene", game_pkg::scene_play, scene);
        end_test("reset and start key", err_before);
    endtask

    task automatic test_gate_blocks();
        int         err_before;
        int         n;
        logic [9:0] exp_x;
        err_before = errors;
        joy1.x = JOY_RIGHT;
        for (n = 1; n <= 20; n++) begin
            pulse_tick();
            exp_x = game_pkg::P1_START.x + 10'(n) * game_pkg::STEP;
            if (exp_x > GATE1_STOP) begin
                exp_x = GATE1_STOP;   // closed gate holds it
            end
            check_char("char1", char_at(exp_x, game_pkg::P1_START.y, 1'b0, 1'b1), char1);
        end
        joy1 = JOY_REST;
        check_char("char0", char_at(game_pkg::P0_START.x, game_pkg::P0_START.y, 1'b0, 1'b1), char0);
        check_gates("gate_open", 3'b000, gate_open);
        end_test("closed gate stops player 1", err_before);
    endtask

    task automatic test_plate_opens_gate();
        int err_before;
        err_before = errors;
        joy0.x = JOY_RIGHT;
        repeat (6) pulse_tick();
        joy0 = JOY_REST;
        check_char("char0", char_at(10'd62, game_pkg::P0_START.y, 1'b0, 1'b1), char0);
        check_gates("gate_open", 3'b001, gate_open);
        joy1.x = JOY_RIGHT;
        repeat (4) pulse_tick();
        joy1 = JOY_REST;
        check_char("char1", char_at(GATE1_STOP + 10'd20, game_pkg::P1_START.y, 1'b0, 1'b1), char1);
        joy0.x = JOY_LEFT;   // step off the plate
        pulse_tick();
        joy0 = JOY_REST;
        check_char("char0", char_at(10'd57, game_pkg::P0_START.y, 1'b1, 1'b1), char0);
        check_gates("gate_open", 3'b000, gate_open);
        end_test("plate opens gate 1", err_before);
    endtask

    task automatic test_jump();
        int         err_before;
        int         n;
        int         delta;
        int         apex;
        logic [9:0] prev_y;
        logic [9:0] min_y;
        err_before = errors;
        apex = int'(game_pkg::P0_START.y) -
               ((int'(game_pkg::JUMP_HEIGHT) + int'(game_pkg::STEP) - 1) / int'(game_pkg::STEP))
               * int'(game_pkg::STEP);
        joy0.jump = 1'b1;
        pulse_tick();
        joy0.jump = 1'b0;
        check_bit("char0.jumping", 1'b1, char0.jumping);
        prev_y = char0.y;
        min_y  = prev_y;
        n      = 1;
        while (!char0.on_ground && n < 30) begin
            pulse_tick();
            n++;
            delta = int'(char0.y) - int'(prev_y);
            checks++;
            if (delta != 0 && delta != int'(game_pkg::STEP) && delta != -int'(game_pkg::STEP)) begin
                errors++;
                $display("Error at %0t: char0.y step expected 0 or %0d, got %0d",
                         $time, game_pkg::STEP, delta);
            end
            if (char0.y < min_y) begin
                min_y = char0.y;
            end
            prev_y = char0.y;
        end
        if (!char0.on_ground) begin
            errors++;
            $display("player 0 did not land within 30 ticks of the jump");
        end
        check_count("char0 apex y", apex, int'(min_y));
        check_char("char0", char_at(10'd57, game_pkg::P0_START.y, 1'b1, 1'b1), char0);
        end_test("player 0 jump", err_before);
    endtask

    task automatic test_spike_lose();
        int err_before;
        int n;
        err_before = errors;
        apply_reset();
        send_key(game_pkg::KEY_START);
        check_scene("scene", game_pkg::scene_play, scene);
        joy1.x = JOY_RIGHT;
        pulse_tick();
        joy1 = JOY_REST;
        check_char("char1", char_at(10'd37, game_pkg::P1_START.y, 1'b0, 1'b1), char1);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_bit("spike_on", spike_expected(since_reset), spike_on);
            check_scene("scene", game_pkg::scene_play, scene);
        end while (!spike_on && n < 400);
        if (!spike_on) begin
            errors++;
            $display("spike_on never rose while player 1 stood on the spike");
        end
        @(negedge clk);
        check_scene("scene", game_pkg::scene_lose, scene);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (scene == game_pkg::scene_lose && n < 200);
        check_count("lose scene cycles", LOSE_SECONDS * LOSE_TICKS + 1, n);
        check_scene("scene", game_pkg::scene_start, scene);
        end_test("spike contact and lose hold", err_before);
    endtask

    initial begin
        void'($urandom(43280));
        apply_reset();
        test_reset_and_start();
        test_gate_blocks();
        test_plate_opens_gate();
        test_jump();
        test_spike_lose();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/game_pkg.sv
source/tile_map.sv
source/character_motion.sv
source/gate_control.sv
source/spike_timer.sv
source/scene_fsm.sv
source/game_top.sv
verification/game_assertions.sv
verification/game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module game_tb -f src.f -o game_sim

./obj_dir/game_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^TB PASSED$" sim.log
